/* list.f */
+incdir+src
src/memArbTypesPkg.sv
src/memArbStatePkg.sv
src/arbConfig.sv
src/memRequestArbiter.sv
src/memBackend.sv
src/memSubsystem.sv
testbench/memArbTb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing -f list.f --top-module memArbTb -Mdir obj_dir -o memArbTb \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/memArbTb > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "test failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no pass message in the log"; exit 1; }
exit 0

/* src/arbConfig.sv */
`timescale 1ns/1ps

`include "memArb_params.svh"

// config registers beside the arbiter
// sel 0 holds the per-cache enable mask
// sel 1 holds the burst-length limit
module arbConfig import memArbTypesPkg::*; (
	input  logic       clk,
	input  logic       rst,
	// register write strobe and address
	input  logic       cfgWe,
	input  logic       cfgSel,
	input  memWord_t   cfgWdata,
	// read-back of the selected register
	output memWord_t   cfgRdata,
	// control outputs to the arbiter
	output cacheMask_t cacheEnable,
	output transSize_t burstLimit
);

	// enable mask register
	// every cache may be granted after reset
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cacheEnable <= '1;
		end else if (cfgWe && !cfgSel) begin
			// low bits only, one per cache
			cacheEnable <= cfgWdata[`MA_NUM_CACHES-1:0];
		end
	end

	// burst limit register
	// reset to the largest burst, so no clipping by default
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			burstLimit <= transSize_t'(`MA_MAX_TRANS - 1);
		end else if (cfgWe && cfgSel) begin
			burstLimit <= cfgWdata[$clog2(`MA_MAX_TRANS)-1:0];
		end
	end

	// read-back mux
	// both registers come back zero-extended to a full word
	always_comb begin
		if (cfgSel) begin
			cfgRdata = memWord_t'(burstLimit);
		end else begin
			cfgRdata = memWord_t'(cacheEnable);
		end
	end

endmodule

/* src/memArbStatePkg.sv */
// arbiter FSM encoding
package memArbStatePkg;

	// IDLE scans for a requester
	// READ runs one burst for the granted cache
	// WRITE commits the single slave word
	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE
	} arbState_t;

endpackage

/* src/memArbTypesPkg.sv */
`include "memArb_params.svh"

// vector types shared by the arbiter, the backend and the config block
package memArbTypesPkg;

	// word address as seen by caches and writer
	typedef logic [`MA_ADDR_W-1:0] memAddr_t;

	// one data word
	typedef logic [`MA_DATA_W-1:0] memWord_t;

	// burst length, wide enough for MA_MAX_TRANS-1
	typedef logic [$clog2(`MA_MAX_TRANS)-1:0] transSize_t;

	// rotating pointer to one cache
	typedef logic [$clog2(`MA_NUM_CACHES)-1:0] cacheIdx_t;

	// one bit per cache
	// requests, valid strobes, done pulses and the enable mask
	typedef logic [`MA_NUM_CACHES-1:0] cacheMask_t;

endpackage

/* src/memArb_params.svh */
`ifndef MEMARB_PARAMS_SVH
`define MEMARB_PARAMS_SVH

// number of caches that share the memory
`define MA_NUM_CACHES 4

// burst count range, sizes run 0 .. MA_MAX_TRANS-1
`define MA_MAX_TRANS 64

// word address and data widths
`define MA_ADDR_W 25
`define MA_DATA_W 32

// address bits actually stored in the backend
// upper address bits wrap
`define MA_MEM_DEPTH_LOG2 10

// cycles from a read command to its data
`define MA_RD_LATENCY 3

`endif

/* src/memBackend.sv */
`timescale 1ns/1ps

`include "memArb_params.svh"

// on-chip word memory in place of the SDRAM controller
// reads return after a fixed latency, pipelined
// writes land in one cycle
module memBackend import memArbTypesPkg::*; (
	input  logic     clk,
	input  logic     rst,
	// command side
	input  memAddr_t memAddr,
	input  logic     memRead,
	input  logic     memWrite,
	input  memWord_t memWdata,
	// return side, MA_RD_LATENCY cycles after memRead
	output logic     memValid,
	output memWord_t memRdata
);

	localparam int DEPTH = 1 << `MA_MEM_DEPTH_LOG2;
	localparam int LAT = `MA_RD_LATENCY;

	// storage
	memWord_t mem [DEPTH];

	// stored part of the address
	// upper bits ignored, so addresses wrap
	logic [`MA_MEM_DEPTH_LOG2-1:0] wordIdx;

	// read pipeline
	// stage 0 holds the array output, last stage drives the outputs
	logic [LAT-1:0] validPipe;
	memWord_t       dataPipe [LAT];

	assign wordIdx = memAddr[`MA_MEM_DEPTH_LOG2-1:0];

	// single-cycle write port
	always_ff @(posedge clk) begin
		if (memWrite) begin
			mem[wordIdx] <= memWdata;
		end
	end

	// valid shift chain
	// the only state here that needs a known value after reset
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			validPipe <= '0;
		end else begin
			validPipe[0] <= memRead;
			for (int i = 1; i < LAT; i++) begin
				validPipe[i] <= validPipe[i-1];
			end
		end
	end

	// data shift chain, runs alongside the valids
	// a new read can enter every cycle
	always_ff @(posedge clk) begin
		if (memRead) begin
			dataPipe[0] <= mem[wordIdx];
		end
		for (int i = 1; i < LAT; i++) begin
			dataPipe[i] <= dataPipe[i-1];
		end
	end

	// outputs from the last stage
	assign memValid = validPipe[LAT-1];
	assign memRdata = dataPipe[LAT-1];

endmodule

/* src/memRequestArbiter.sv */
`timescale 1ns/1ps

`include "memArb_params.svh"

// round-robin arbiter between the caches and the slave writer
// one transfer runs at a time against the memory backend
module memRequestArbiter import memArbTypesPkg::*, memArbStatePkg::*; (
	input  logic                           clk,
	input  logic                           rst,
	// cache read side
	input  memAddr_t   [`MA_NUM_CACHES-1:0] addrCache,
	input  transSize_t [`MA_NUM_CACHES-1:0] transSize,
	input  cacheMask_t                      readReq,
	output cacheMask_t                      readValid,
	output memWord_t   [`MA_NUM_CACHES-1:0] readData,
	output cacheMask_t                      doneRead,
	// single-word write side
	input  memAddr_t                        writeAddr,
	input  memWord_t                        writeData,
	input  logic                            writeReq,
	output logic                            doneWrite,
	// from the config block
	input  cacheMask_t                      cacheEnable,
	input  transSize_t                      burstLimit,
	// backend command side
	output memAddr_t                        memAddr,
	output logic                            memRead,
	output logic                            memWrite,
	output memWord_t                        memWdata,
	// backend return side
	input  logic                            memValid,
	input  memWord_t                        memRdata
);

	arbState_t  state;
	arbState_t  nextState;
	// cache currently looked at, and the granted one while in READ
	cacheIdx_t  ptr;
	// effective length of the running burst
	transSize_t burstLen;
	// words sent to the backend and words come back
	// they differ while reads are in flight
	transSize_t issueCnt;
	transSize_t rcvCnt;
	// per-cycle decisions
	logic       acceptRead;
	logic       acceptWrite;
	logic       readDone;
	logic       advance;
	transSize_t effLen;

	// burst is clipped to the configured limit
	assign effLen = (transSize[ptr] < burstLimit) ? transSize[ptr] : burstLimit;

	// grant decision in IDLE
	// read of the pointed cache wins over a pending write
	assign acceptRead = (state == IDLE) && readReq[ptr] && cacheEnable[ptr];
	assign acceptWrite = (state == IDLE) && !acceptRead && writeReq;

	// burst ends once every requested word has returned
	assign readDone = (state == READ) && (rcvCnt == burstLen);

	// pointer moves on idle cycles and after a finished burst
	// a write leaves it where it is
	assign advance = ((state == IDLE) && !acceptRead && !acceptWrite) || readDone;

	// next state
	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (acceptRead) begin
					nextState = READ;
				end else if (acceptWrite) begin
					nextState = WRITE;
				end
			end
			READ: begin
				if (readDone) begin
					nextState = IDLE;
				end
			end
			// single word, always one cycle
			WRITE: begin
				nextState = IDLE;
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	// backend commands
	always_comb begin
		memAddr = '0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memWdata = '0;
		doneWrite = 1'b0;
		if (state == READ) begin
			// one consecutive address per cycle until n are out
			memRead = (issueCnt != burstLen);
			memAddr = addrCache[ptr] + memAddr_t'(issueCnt);
		end else if (state == WRITE) begin
			// write commits and completes in the same cycle
			memWrite = 1'b1;
			memAddr = writeAddr;
			memWdata = writeData;
			doneWrite = 1'b1;
		end
	end

	// return path
	// data goes only to the granted cache, others see zero
	always_comb begin
		readValid = '0;
		readData = '0;
		doneRead = '0;
		if (state == READ) begin
			if (memValid) begin
				readValid[ptr] = 1'b1;
				readData[ptr] = memRdata;
			end
			doneRead[ptr] = readDone;
		end
	end

	// FSM, pointer and burst counters
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= IDLE;
			ptr <= '0;
			burstLen <= '0;
			issueCnt <= '0;
			rcvCnt <= '0;
		end else begin
			state <= nextState;
			if (advance) begin
				ptr <= ptr + 1'b1;
			end
			if (state == IDLE) begin
				// counters start fresh for every burst
				issueCnt <= '0;
				rcvCnt <= '0;
				if (acceptRead) begin
					// length fixed at grant time
					burstLen <= effLen;
				end
			end else if (state == READ) begin
				if (memRead) begin
					issueCnt <= issueCnt + 1'b1;
				end
				if (memValid) begin
					rcvCnt <= rcvCnt + 1'b1;
				end
			end
		end
	end

endmodule

/* src/memSubsystem.sv */
`timescale 1ns/1ps

// shared memory front end
// config block steers the arbiter, arbiter drives the backend
module memSubsystem import memArbTypesPkg::*; (
	input  logic                                 clk,
	input  logic                                 rst,
	// cache read side
	input  memAddr_t   [$bits(cacheMask_t)-1:0] addrCache,
	input  transSize_t [$bits(cacheMask_t)-1:0] transSize,
	input  cacheMask_t                          readReq,
	output cacheMask_t                          readValid,
	output memWord_t   [$bits(cacheMask_t)-1:0] readData,
	output cacheMask_t                          doneRead,
	// write side
	input  memAddr_t                            writeAddr,
	input  memWord_t                            writeData,
	input  logic                                writeReq,
	output logic                                doneWrite,
	// config side
	input  logic                                cfgWe,
	input  logic                                cfgSel,
	input  memWord_t                            cfgWdata,
	output memWord_t                            cfgRdata
);

	// config to arbiter
	cacheMask_t cacheEnable;
	transSize_t burstLimit;

	// arbiter to backend and back
	memAddr_t   memAddr;
	logic       memRead;
	logic       memWrite;
	memWord_t   memWdata;
	logic       memValid;
	memWord_t   memRdata;

	arbConfig config_i (
		.clk(clk),
		.rst(rst),
		.cfgWe(cfgWe),
		.cfgSel(cfgSel),
		.cfgWdata(cfgWdata),
		.cfgRdata(cfgRdata),
		.cacheEnable(cacheEnable),
		.burstLimit(burstLimit)
	);

	memRequestArbiter arbiter_i (
		.clk(clk),
		.rst(rst),
		.addrCache(addrCache),
		.transSize(transSize),
		.readReq(readReq),
		.readValid(readValid),
		.readData(readData),
		.doneRead(doneRead),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeReq(writeReq),
		.doneWrite(doneWrite),
		.cacheEnable(cacheEnable),
		.burstLimit(burstLimit),
		.memAddr(memAddr),
		.memRead(memRead),
		.memWrite(memWrite),
		.memWdata(memWdata),
		.memValid(memValid),
		.memRdata(memRdata)
	);

	memBackend backend_i (
		.clk(clk),
		.rst(rst),
		.memAddr(memAddr),
		.memRead(memRead),
		.memWrite(memWrite),
		.memWdata(memWdata),
		.memValid(memValid),
		.memRdata(memRdata)
	);

endmodule

/* testbench/memArbTb.sv */
`timescale 1ns/1ps

`include "memArb_params.svh"

// self-checking testbench for the shared memory front end
// operations come from the data file, expected words from a memory model
module memArbTb import memArbTypesPkg::*, memArbStatePkg::*; ();

	localparam int numCaches = `MA_NUM_CACHES;
	localparam int addrWrap = (1 << `MA_MEM_DEPTH_LOG2) - 1;
	localparam int opCfg = 0;
	localparam int opWrite = 1;
	localparam int opRead = 2;

	logic clk;
	logic rst;
	memAddr_t [numCaches-1:0] addrCache;
	transSize_t [numCaches-1:0] transSize;
	cacheMask_t readReq;
	cacheMask_t readValid;
	memWord_t [numCaches-1:0] readData;
	cacheMask_t doneRead;
	memAddr_t writeAddr;
	memWord_t writeData;
	logic writeReq;
	logic doneWrite;
	logic cfgWe;
	logic cfgSel;
	memWord_t cfgWdata;
	memWord_t cfgRdata;

	// reference model of memory and config registers
	memWord_t model [int];
	cacheMask_t enModel;
	int limitModel;
	// per-cache request bookkeeping, driver side
	int reqAddr [numCaches];
	int expLen [numCaches];
	int waitCnt [numCaches];
	int releasedCnt [numCaches];
	// monitor side
	int wordsSeen [numCaches];
	int doneCnt [numCaches];
	int writesSeen;
	int writesIssued;
	int valueErrs;
	int otherErrs;
	int watchdogCycles;
	logic armed = 1'b0;
	// flattened operation stream from the file
	int unsigned ops [$];

	memSubsystem dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// compare and log one mismatch
	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			valueErrs++;
		end
	endtask

	task automatic reportProblem(input string msg);
		$display("Problem at %0t: %s", $time, msg);
		otherErrs++;
	endtask

	// next drive point, 10 ns after the rising edge
	task automatic stepCycle();
		@(posedge clk);
		#10;
		for (int c = 0; c < numCaches; c++) begin
			// request ends once its done pulse was seen
			if (doneCnt[c] != releasedCnt[c]) begin
				readReq[c] = 1'b0;
				releasedCnt[c] = doneCnt[c];
			end
			// delayed raise
			if (waitCnt[c] > 0) begin
				waitCnt[c]--;
				if (waitCnt[c] == 0) begin
					readReq[c] = 1'b1;
				end
			end
		end
	endtask

	// any enabled cache still waiting for service
	function automatic logic anyServable();
		logic busy;
		busy = 1'b0;
		for (int c = 0; c < numCaches; c++) begin
			if (enModel[c] && (readReq[c] || waitCnt[c] > 0)) begin
				busy = 1'b1;
			end
		end
		return busy;
	endfunction

	// response monitor on the falling edge, where outputs are settled
	initial begin
		int active;
		active = -1;
		writesSeen = 0;
		for (int c = 0; c < numCaches; c++) begin
			wordsSeen[c] = 0;
			doneCnt[c] = 0;
		end
		forever begin
			@(negedge clk);
			if (!rst) begin
				if ($countones(readValid) > 1 || $countones(doneRead) > 1) begin
					reportProblem("two caches strobed in the same cycle");
				end
				if (doneWrite) begin
					writesSeen++;
				end
				for (int c = 0; c < numCaches; c++) begin
					if (readValid[c] || doneRead[c]) begin
						if (!readReq[c] || !enModel[c]) begin
							reportProblem($sformatf("cache %0d answered without enabled request", c));
						end
						if (active != -1 && active != c) begin
							reportProblem("bursts of two caches interleaved");
						end
						active = c;
					end
					if (readValid[c]) begin
						checkValue($sformatf("readData[%0d]", c),
							model[(reqAddr[c] + wordsSeen[c]) & addrWrap], readData[c]);
						wordsSeen[c]++;
					end
					if (doneRead[c]) begin
						checkValue($sformatf("word count at doneRead[%0d]", c), expLen[c], wordsSeen[c]);
						wordsSeen[c] = 0;
						doneCnt[c]++;
						active = -1;
					end
				end
			end
		end
	end

	// watchdog sized from the requested words
	initial begin
		arbState_t st;
		wait (armed);
		repeat (watchdogCycles) @(posedge clk);
		st = dut_i.arbiter_i.state;
		$display("timeout after %0d cycles, arbiter stuck in %s", watchdogCycles, st.name());
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int fd;
		int n;
		int kind;
		int totalWords;
		int unsigned a;
		int unsigned b;
		int unsigned mask;
		logic [7:0] tok;
		logic [8*128-1:0] line;
		logic endSeen;
		rst = 1'b1;
		addrCache = '0;
		transSize = '0;
		readReq = '0;
		writeAddr = '0;
		writeData = '0;
		writeReq = 1'b0;
		cfgWe = 1'b0;
		cfgSel = 1'b0;
		cfgWdata = '0;
		void'($urandom(63));
		for (int c = 0; c < numCaches; c++) begin
			reqAddr[c] = 0;
			expLen[c] = 0;
			waitCnt[c] = 0;
			releasedCnt[c] = 0;
		end
		enModel = '1;
		limitModel = `MA_MAX_TRANS - 1;
		valueErrs = 0;
		otherErrs = 0;
		writesIssued = 0;
		totalWords = 0;
		endSeen = 1'b0;
		// whole file parsed up front
		fd = $fopen("testbench/memArb_testdata.txt", "r");
		if (fd == 0) begin
			reportProblem("cannot open the stimulus file");
		end
		while (fd != 0 && !endSeen) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1) begin
				reportProblem("stimulus file ends without an E line");
				endSeen = 1'b1;
			end else if (tok == "#") begin
				n = $fgets(line, fd);
			end else if (tok == "C" || tok == "W") begin
				n = $fscanf(fd, "%h %h", a, b);
				ops.push_back((tok == "C") ? opCfg : opWrite);
				ops.push_back(a);
				ops.push_back(b);
			end else if (tok == "R") begin
				n = $fscanf(fd, "%h", mask);
				ops.push_back(opRead);
				ops.push_back(mask);
				for (int c = 0; c < numCaches; c++) begin
					if (mask[c]) begin
						n = $fscanf(fd, "%h %h", a, b);
						ops.push_back(a);
						ops.push_back(b);
						totalWords += b;
					end
				end
			end else if (tok == "E") begin
				endSeen = 1'b1;
			end else begin
				reportProblem("unknown opcode in the stimulus file");
				endSeen = 1'b1;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		watchdogCycles = 2000 + 80 * totalWords;
		armed = 1'b1;
		repeat (10) @(posedge clk);
		#10;
		rst = 1'b0;
		// register values straight out of reset
		checkValue("cfgRdata mask after reset", (1 << numCaches) - 1, cfgRdata);
		cfgSel = 1'b1;
		stepCycle();
		checkValue("cfgRdata limit after reset", `MA_MAX_TRANS - 1, cfgRdata);
		while (ops.size() > 0) begin
			kind = int'(ops.pop_front());
			if (kind == opCfg) begin
				a = ops.pop_front();
				b = ops.pop_front();
				cfgSel = a[0];
				cfgWdata = b;
				cfgWe = 1'b1;
				stepCycle();
				cfgWe = 1'b0;
				if (a[0]) begin
					limitModel = b & (`MA_MAX_TRANS - 1);
					checkValue("cfgRdata limit", limitModel, cfgRdata);
				end else begin
					enModel = b[numCaches-1:0];
					checkValue("cfgRdata mask", b & ((1 << numCaches) - 1), cfgRdata);
				end
				// a restored mask releases held requests
				while (anyServable()) stepCycle();
			end else if (kind == opWrite) begin
				a = ops.pop_front();
				b = ops.pop_front();
				model[a & addrWrap] = b;
				writeAddr = memAddr_t'(a);
				writeData = b;
				writeReq = 1'b1;
				n = writesSeen;
				stepCycle();
				while (writesSeen == n) stepCycle();
				writeReq = 1'b0;
				writesIssued++;
			end else begin
				mask = ops.pop_front();
				for (int c = 0; c < numCaches; c++) begin
					if (mask[c]) begin
						a = ops.pop_front();
						b = ops.pop_front();
						reqAddr[c] = a;
						expLen[c] = (b < limitModel) ? b : limitModel;
						addrCache[c] = memAddr_t'(a);
						transSize[c] = transSize_t'(b);
						waitCnt[c] = 1 + int'($urandom % 6);
					end
				end
				while (anyServable()) stepCycle();
			end
		end
		// quiet period to catch stray strobes
		repeat (20) stepCycle();
		for (int c = 0; c < numCaches; c++) begin
			if (readReq[c] || waitCnt[c] > 0) begin
				reportProblem($sformatf("cache %0d request never served", c));
			end
		end
		checkValue("doneWrite pulse count", writesIssued, writesSeen);
		$display("errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
		if (valueErrs == 0 && otherErrs == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* testbench/memArb_testdata.txt */
# opcode then hex fields, C sel value / W addr data / E ends the list
# R mask, then addr size for each set cache bit from cache 0 upward
W 010 11110010
W 011 22220011
W 012 33330012
W 013 44440013
W 014 55550014
W 015 66660015
W 016 77770016
W 017 88880017
W 3fe 9999a3fe
W 3ff aaaab3ff
W 000 bbbbc000
W 001 ccccd001
# one burst alone, then all caches together with a wrapping burst
R 1 010 8
R f 010 4 012 3 3fe 4 014 2
# caches 1 and 3 masked off and left waiting
C 0 5
R b 010 2 011 3 015 2
W 016 0badf00d
C 0 ffffffff
# burst limit below the requested size
C 1 2
R 4 010 6
C 1 ffffff05
R 5 012 9 017 0
R 2 3fe 0
C 1 3f
R 8 3fe 4
E
